// File: flist.f
mgmt_pkg.sv
mgmt_bus_bridge.sv
fan_tachometer.sv
relay_sequencer.sv
frontpanel_spi.sv
mgmt_register_file.sv
mgmt_subsystem.sv
mgmt_subsystem_tb.sv

// File: mgmt_subsystem_tb.sv
`timescale 1ns/1ps

module mgmt_subsystem_tb import mgmt_pkg::*; ();

	// Expected host response, care clear for fan reads
	typedef struct packed {
		logic        care;
		logic [15:0] data;
	} rsp_exp_t;

	logic                          sys_clk;
	logic                          reset;
	logic                          host_req;
	mgmt_req_t                     host_cmd;
	wire                           host_ack;
	mgmt_rsp_t                     host_rsp;
	logic [NUM_FANS-1:0]           fan_tach;
	muxsel_t [NUM_TRIG_OUT-1:0]    muxsel;
	wire                           relay_en;
	wire                           relay_dir;
	wire [1:0]                     relay_channel;
	logic                          relay_done;
	wire                           frontpanel_sck;
	wire                           frontpanel_mosi;
	wire                           frontpanel_cs_n;

	// Reference model state
	logic [15:0] ref_scratch;
	muxsel_t     ref_mux [NUM_TRIG_OUT];
	logic        ref_relay_busy;
	logic        ref_front_busy;
	rsp_exp_t    exp_q [$];
	logic [15:0] lfsr_state;

	// Port monitors
	int          relay_en_pulses;
	int          relay_moves;
	logic [2:0]  relay_seen;
	int          spi_bits_seen;
	int          spi_frames;
	int          cs_low_count;
	logic [7:0]  spi_byte;

	mgmt_subsystem u_mgmt_subsystem (
		.sys_clk(sys_clk),
		.reset(reset),
		.host_req(host_req),
		.host_cmd(host_cmd),
		.host_ack(host_ack),
		.host_rsp(host_rsp),
		.fan_tach(fan_tach),
		.muxsel(muxsel),
		.relay_en(relay_en),
		.relay_dir(relay_dir),
		.relay_channel(relay_channel),
		.relay_done(relay_done),
		.frontpanel_sck(frontpanel_sck),
		.frontpanel_mosi(frontpanel_mosi),
		.frontpanel_cs_n(frontpanel_cs_n)
	);

	initial begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk;
	end

	////////////////////////////////////////
	// Reporting, random bits and model

	task automatic abort_run(input string why);
		$display("ERROR: %s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
			abort_run("value mismatch");
		end
	endtask

	// 16-bit Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One LFSR step per bit taken
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] val;
		val = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_step(lfsr_state);
			val = {val[14:0], lfsr_state[0]};
		end
		return val;
	endfunction

	// Register map as seen from the host
	function automatic logic [15:0] expected_read(input logic [7:0] addr);
		if (addr == REG_ID)
			return MGMT_ID;
		if (addr == REG_SCRATCH)
			return ref_scratch;
		if ((addr >= REG_MUXSEL_BASE) && (addr < REG_MUXSEL_BASE + NUM_TRIG_OUT))
			return {12'd0, ref_mux[addr - REG_MUXSEL_BASE]};
		if (addr == REG_RELAY_STAT)
			return {15'd0, ref_relay_busy};
		if (addr == REG_FRONT_STAT)
			return {15'd0, ref_front_busy};
		return 16'h0000;
	endfunction

	////////////////////////////////////////
	// Host four-phase access

	task automatic host_transfer(input reg_op_t op, input logic [7:0] addr,
			input logic [15:0] wdata, output logic [15:0] rdata);
		int t;
		@(posedge sys_clk);
		#2;
		host_cmd = '{op: op, addr: addr, wdata: wdata};
		host_req = 1'b1;
		t = 0;
		while (host_ack !== 1'b1) begin
			@(posedge sys_clk);
			#2;
			t++;
			if (t > 50)
				abort_run("host_ack never rose");
		end
		rdata = host_rsp.rdata;
		host_req = 1'b0;
		t = 0;
		while (host_ack !== 1'b0) begin
			@(posedge sys_clk);
			#2;
			t++;
			if (t > 50)
				abort_run("host_ack never fell after req dropped");
		end
	endtask

	task automatic do_write(input logic [7:0] addr, input logic [15:0] data);
		logic [15:0] rsp;
		exp_q.push_back('{care: 1'b1, data: 16'h0000});
		host_transfer(OP_WRITE, addr, data, rsp);
		if (addr == REG_SCRATCH)
			ref_scratch = data;
		if ((addr >= REG_MUXSEL_BASE) && (addr < REG_MUXSEL_BASE + NUM_TRIG_OUT))
			ref_mux[addr - REG_MUXSEL_BASE] = data[3:0];
	endtask

	task automatic do_read(input logic [7:0] addr, input logic care, output logic [15:0] data);
		exp_q.push_back('{care: care, data: expected_read(addr)});
		host_transfer(OP_READ, addr, 16'h0000, data);
	endtask

	// Response compare, sampled mid cycle
	initial begin : compare_rsp
		logic     ack_q;
		rsp_exp_t e;
		ack_q = 1'b0;
		forever begin
			@(negedge sys_clk);
			if ((host_ack === 1'b1) && !ack_q) begin
				if (exp_q.size() == 0)
					abort_run("host_ack with no transaction pending");
				e = exp_q.pop_front();
				if (e.care)
					check_value("host_rsp", host_rsp.rdata, e.data);
			end
			ack_q = (host_ack === 1'b1);
		end
	end

	////////////////////////////////////////
	// Pin models and monitors

	task automatic spin_fan(input int idx, input int period);
		int phase;
		phase = 0;
		forever begin
			@(posedge sys_clk);
			#2;
			fan_tach[idx] = (phase < period / 2);
			phase = (phase + 1) % period;
		end
	endtask

	initial spin_fan(0, 40);
	initial spin_fan(1, 25);

	// Relay driver answers after a random delay
	initial begin : relay_responder
		int delay;
		int t;
		forever begin
			@(posedge sys_clk);
			#2;
			if ((relay_en === 1'b1) && !relay_done) begin
				delay = 32 + rand_bits(4);
				repeat (delay) @(posedge sys_clk);
				#2;
				relay_done = 1'b1;
				t = 0;
				while (relay_en !== 1'b0) begin
					@(posedge sys_clk);
					#2;
					t++;
					if (t > 50)
						abort_run("relay_en stayed high after relay_done");
				end
				relay_done = 1'b0;
				relay_moves++;
			end
		end
	end

	// Count en pulses and keep the move each one carries
	always @(negedge sys_clk) begin : relay_monitor
		logic en_q;
		if ((relay_en === 1'b1) && !en_q) begin
			relay_en_pulses++;
			relay_seen = {relay_channel, relay_dir};
		end
		en_q = (relay_en === 1'b1);
	end

	// Mode 0, data valid at the SCK rising edge
	always @(posedge frontpanel_sck) begin
		if (frontpanel_cs_n === 1'b0) begin
			spi_byte = {spi_byte[6:0], frontpanel_mosi};
			spi_bits_seen++;
		end
	end

	always @(negedge frontpanel_cs_n)
		cs_low_count++;

	always @(posedge frontpanel_cs_n)
		if (reset === 1'b0)
			spi_frames++;

	////////////////////////////////////////
	// Stimulus

	initial begin : stimulus
		logic [15:0] rd;
		logic [15:0] val;
		logic [2:0]  move;
		int          t;
		int          cnt_exp;
		reset = 1'b1;
		host_req = 1'b0;
		host_cmd = '0;
		fan_tach = '0;
		relay_done = 1'b0;
		lfsr_state = 16'd3172;
		ref_scratch = 16'h0000;
		ref_relay_busy = 1'b0;
		ref_front_busy = 1'b0;
		relay_en_pulses = 0;
		relay_moves = 0;
		spi_bits_seen = 0;
		spi_frames = 0;
		cs_low_count = 0;
		spi_byte = 8'h00;
		for (int i = 0; i < NUM_TRIG_OUT; i++)
			ref_mux[i] = 4'h0;
		repeat (8) @(posedge sys_clk);
		#2;
		reset = 1'b0;

		// Reset values on ports and registers
		check_value("host_ack", host_ack, 1'b0);
		check_value("relay_en", relay_en, 1'b0);
		check_value("frontpanel_sck", frontpanel_sck, 1'b0);
		check_value("frontpanel_cs_n", frontpanel_cs_n, 1'b1);
		do_read(REG_ID, 1'b1, rd);
		do_read(REG_SCRATCH, 1'b1, rd);
		for (int i = 0; i < NUM_TRIG_OUT; i++)
			do_read(REG_MUXSEL_BASE + i, 1'b1, rd);

		// Scratch, unmapped space and the ID word
		for (int i = 0; i < 6; i++) begin
			do_write(REG_SCRATCH, rand_bits(16));
			do_read(REG_SCRATCH, 1'b1, rd);
		end
		do_write(REG_ID, rand_bits(16));
		do_read(REG_ID, 1'b1, rd);
		do_write(8'h50, rand_bits(16));
		do_read(8'h02, 1'b1, rd);
		do_read(8'h12, 1'b1, rd);
		do_read(8'h2C, 1'b1, rd);
		do_read(8'h50, 1'b1, rd);
		do_read(8'hFF, 1'b1, rd);

		// Mux selects with junk in the upper bits
		for (int i = 0; i < NUM_TRIG_OUT; i++)
			do_write(REG_MUXSEL_BASE + i, rand_bits(16));
		for (int i = 0; i < NUM_TRIG_OUT; i++) begin
			check_value($sformatf("muxsel[%0d]", i), muxsel[i], ref_mux[i]);
			do_read(REG_MUXSEL_BASE + i, 1'b1, rd);
		end

		// Two full tach windows and a margin, counts within one of nominal
		repeat (2 * TACH_WINDOW + 20) @(posedge sys_clk);
		do_read(REG_FAN_BASE, 1'b0, rd);
		cnt_exp = TACH_WINDOW / 40;
		if ((int'(rd) < cnt_exp - 1) || (int'(rd) > cnt_exp + 1))
			check_value("fan0 tach_count", rd, cnt_exp);
		do_read(REG_FAN_BASE + 1, 1'b0, rd);
		cnt_exp = TACH_WINDOW / 25;
		if ((int'(rd) < cnt_exp - 1) || (int'(rd) > cnt_exp + 1))
			check_value("fan1 tach_count", rd, cnt_exp);

		// Relay move, then a second one while busy
		move = rand_bits(3);
		do_write(REG_RELAY_CTRL, {13'd0, move});
		ref_relay_busy = 1'b1;
		do_read(REG_RELAY_STAT, 1'b1, rd);
		do_write(REG_RELAY_CTRL, {13'd0, ~move});
		do_read(REG_RELAY_STAT, 1'b1, rd);
		t = 0;
		while (relay_moves < 1) begin
			@(posedge sys_clk);
			t++;
			if (t > 500)
				abort_run("relay handshake did not finish");
		end
		ref_relay_busy = 1'b0;
		do_read(REG_RELAY_STAT, 1'b1, rd);
		check_value("relay_en pulses", relay_en_pulses, 1);
		check_value("relay channel and dir", relay_seen, move);

		// Front panel byte on SPI, busy while it shifts
		val = rand_bits(8);
		spi_bits_seen = 0;
		spi_frames = 0;
		cs_low_count = 0;
		do_write(REG_FRONT_DATA, val);
		ref_front_busy = 1'b1;
		do_read(REG_FRONT_STAT, 1'b1, rd);
		t = 0;
		while (spi_frames < 1) begin
			@(posedge sys_clk);
			t++;
			if (t > 500)
				abort_run("frontpanel_cs_n never returned high");
		end
		ref_front_busy = 1'b0;
		check_value("cs_n low periods", cs_low_count, 1);
		check_value("mosi bit count", spi_bits_seen, 8);
		check_value("frontpanel_mosi byte", spi_byte, val[7:0]);
		do_read(REG_FRONT_STAT, 1'b1, rd);

		// Let the compare process drain
		t = 0;
		while (exp_q.size() != 0) begin
			@(posedge sys_clk);
			t++;
			if (t > 20)
				abort_run("responses left unchecked");
		end
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: mgmt_subsystem.sv
`timescale 1ns/1ps

module mgmt_subsystem import mgmt_pkg::*; (
	input wire                            sys_clk,
	input wire                            reset,

	// Host register port
	input wire                            host_req,
	input wire mgmt_req_t                 host_cmd,
	output wire                           host_ack,
	output mgmt_rsp_t                     host_rsp,

	// Fan tach pins
	input wire [NUM_FANS-1:0]             fan_tach,

	// Trigger crossbar selects
	output muxsel_t [NUM_TRIG_OUT-1:0]    muxsel,

	// Relay driver
	output wire                           relay_en,
	output wire                           relay_dir,
	output wire [1:0]                     relay_channel,
	input wire                            relay_done,

	// Front panel SPI
	output wire                           frontpanel_sck,
	output wire                           frontpanel_mosi,
	output wire                           frontpanel_cs_n
);

	// Internal register bus
	wire                      bus_strobe;
	mgmt_req_t                bus_cmd;
	wire                      rd_valid;
	mgmt_rsp_t                rd_rsp;

	// Peripheral links
	wire [NUM_FANS-1:0][15:0] tach_count;
	wire                      relay_start;
	relay_cmd_t               relay_cmd;
	wire                      relay_busy;
	wire                      front_start;
	wire [7:0]                front_data;
	wire                      front_busy;

	////////////////////////////////////////
	// Host bridge and register file

	mgmt_bus_bridge u_bridge (
		.sys_clk(sys_clk),
		.reset(reset),
		.host_req(host_req),
		.host_cmd(host_cmd),
		.host_ack(host_ack),
		.host_rsp(host_rsp),
		.bus_strobe(bus_strobe),
		.bus_cmd(bus_cmd),
		.rd_valid(rd_valid),
		.rd_rsp(rd_rsp)
	);

	mgmt_register_file u_regs (
		.sys_clk(sys_clk),
		.reset(reset),
		.bus_strobe(bus_strobe),
		.bus_cmd(bus_cmd),
		.rd_valid(rd_valid),
		.rd_rsp(rd_rsp),
		.tach_count(tach_count),
		.muxsel(muxsel),
		.relay_start(relay_start),
		.relay_cmd(relay_cmd),
		.relay_busy(relay_busy),
		.front_start(front_start),
		.front_data(front_data),
		.front_busy(front_busy)
	);

	////////////////////////////////////////
	// Peripherals

	// One tachometer per fan pin
	for (genvar i = 0; i < NUM_FANS; i++) begin : g_fan
		fan_tachometer u_tach (
			.sys_clk(sys_clk),
			.reset(reset),
			.tach(fan_tach[i]),
			.tach_count(tach_count[i])
		);
	end

	relay_sequencer u_relay (
		.sys_clk(sys_clk),
		.reset(reset),
		.relay_start(relay_start),
		.relay_cmd(relay_cmd),
		.relay_busy(relay_busy),
		.relay_en(relay_en),
		.relay_dir(relay_dir),
		.relay_channel(relay_channel),
		.relay_done(relay_done)
	);

	frontpanel_spi u_front (
		.sys_clk(sys_clk),
		.reset(reset),
		.front_start(front_start),
		.front_data(front_data),
		.front_busy(front_busy),
		.sck(frontpanel_sck),
		.mosi(frontpanel_mosi),
		.cs_n(frontpanel_cs_n)
	);

endmodule

// File: mgmt_register_file.sv
`timescale 1ns/1ps

module mgmt_register_file import mgmt_pkg::*; (
	input wire                               sys_clk,
	input wire                               reset,

	// Internal register bus
	input wire                               bus_strobe,
	input wire mgmt_req_t                    bus_cmd,
	output logic                             rd_valid,
	output mgmt_rsp_t                        rd_rsp,

	// Fan tachometers
	input wire [NUM_FANS-1:0][15:0]          tach_count,

	// Trigger crossbar selects
	output muxsel_t [NUM_TRIG_OUT-1:0]       muxsel,

	// Relay sequencer
	output logic                             relay_start,
	output relay_cmd_t                       relay_cmd,
	input wire                               relay_busy,

	// Front panel shifter
	output logic                             front_start,
	output logic [7:0]                       front_data,
	input wire                               front_busy
);

	logic [15:0] scratch;
	logic [15:0] rd_next;
	logic [7:0]  fan_off;
	logic [7:0]  mux_off;
	logic        is_fan;
	logic        is_mux;
	logic        wr_en;
	logic        relay_go;
	logic        front_go;

	////////////////////////////////////////
	// Address decode

	// Offsets wrap below the base, so one compare covers the range
	assign fan_off = bus_cmd.addr - REG_FAN_BASE;
	assign mux_off = bus_cmd.addr - REG_MUXSEL_BASE;
	assign is_fan  = (fan_off < NUM_FANS);
	assign is_mux  = (mux_off < NUM_TRIG_OUT);

	assign wr_en = bus_strobe && (bus_cmd.op == OP_WRITE);

	// Starts are dropped while the target is still busy
	assign relay_go = wr_en && (bus_cmd.addr == REG_RELAY_CTRL) && !relay_busy;
	assign front_go = wr_en && (bus_cmd.addr == REG_FRONT_DATA) && !front_busy;

	// Read mux, anything unmapped reads as zero
	always_comb begin
		rd_next = 16'h0000;
		if (bus_cmd.op == OP_READ) begin
			case (bus_cmd.addr)
				REG_ID:         rd_next = MGMT_ID;
				REG_SCRATCH:    rd_next = scratch;
				REG_RELAY_STAT: rd_next = {15'd0, relay_busy};
				REG_FRONT_STAT: rd_next = {15'd0, front_busy};
				default: begin
					if (is_fan)
						rd_next = tach_count[fan_off[FAN_IDX_W-1:0]];
					else if (is_mux)
						rd_next = {12'd0, muxsel[mux_off[MUX_IDX_W-1:0]]};
				end
			endcase
		end
	end

	////////////////////////////////////////
	// Control registers

	always_ff @(posedge sys_clk) begin
		if (reset) begin
			scratch     <= 16'h0000;
			muxsel      <= '0;
			rd_valid    <= 1'b0;
			relay_start <= 1'b0;
			front_start <= 1'b0;
		end else begin
			// Answer every access, reads and writes alike
			rd_valid    <= bus_strobe;
			relay_start <= relay_go;
			front_start <= front_go;

			if (wr_en && (bus_cmd.addr == REG_SCRATCH))
				scratch <= bus_cmd.wdata;

			// Only the low nibble of a select is kept
			if (wr_en && is_mux)
				muxsel[mux_off[MUX_IDX_W-1:0]] <= bus_cmd.wdata[3:0];
		end
	end

	////////////////////////////////////////
	// Read data and start payloads

	always_ff @(posedge sys_clk) begin
		if (bus_strobe)
			rd_rsp.rdata <= rd_next;

		// Bit 0 is dir, bits 2:1 channel, same as the struct layout
		if (relay_go)
			relay_cmd <= relay_cmd_t'(bus_cmd.wdata[2:0]);

		if (front_go)
			front_data <= bus_cmd.wdata[7:0];
	end

endmodule

// File: frontpanel_spi.sv
`timescale 1ns/1ps

module frontpanel_spi import mgmt_pkg::*; (
	input wire          sys_clk,
	input wire          reset,

	// Byte to send
	input wire          front_start,
	input wire [7:0]    front_data,
	output wire         front_busy,

	// SPI mode 0, transmit only
	output logic        sck,
	output wire         mosi,
	output logic        cs_n
);

	typedef enum logic [1:0] {
		IDLE,
		SHIFT,
		DONE
	} spi_state_t;

	spi_state_t           state;
	logic [SPI_DIV_W-1:0] div_cnt;
	logic [2:0]           bit_cnt;
	logic [7:0]           shift_reg;
	logic                 half_tick;

	assign front_busy = (state != IDLE);

	// MSB is always on the wire
	assign mosi = shift_reg[7];

	// End of one SCK half period
	assign half_tick = (div_cnt == SPI_DIV_W'(SPI_HALF_DIV - 1));

	////////////////////////////////////////
	// Shifter FSM

	always_ff @(posedge sys_clk) begin
		if (reset) begin
			state     <= IDLE;
			sck       <= 1'b0;
			cs_n      <= 1'b1;
			div_cnt   <= '0;
			bit_cnt   <= 3'd0;
			shift_reg <= 8'h00;
		end else begin
			case (state)
				// Load the byte and select the panel
				IDLE: begin
					if (front_start) begin
						shift_reg <= front_data;
						cs_n      <= 1'b0;
						sck       <= 1'b0;
						div_cnt   <= '0;
						bit_cnt   <= 3'd0;
						state     <= SHIFT;
					end
				end

				SHIFT: begin
					if (half_tick) begin
						div_cnt <= '0;
						sck     <= ~sck;

						// Falling edge moves the next bit onto mosi
						if (sck) begin
							shift_reg <= {shift_reg[6:0], 1'b0};
							bit_cnt   <= bit_cnt + 3'd1;
							if (bit_cnt == 3'd7)
								state <= DONE;
						end
					end else begin
						div_cnt <= div_cnt + 1'b1;
					end
				end

				// Deselect after the eighth falling edge
				DONE: begin
					cs_n  <= 1'b1;
					state <= IDLE;
				end

				default:
					state <= IDLE;
			endcase
		end
	end

endmodule

// File: relay_sequencer.sv
`timescale 1ns/1ps

module relay_sequencer import mgmt_pkg::*; (
	input wire              sys_clk,
	input wire              reset,

	// Command from the register file
	input wire              relay_start,
	input wire relay_cmd_t  relay_cmd,
	output wire             relay_busy,

	// Relay driver, four-phase en/done
	output logic            relay_en,
	output logic            relay_dir,
	output logic [1:0]      relay_channel,
	input wire              relay_done
);

	typedef enum logic [1:0] {
		IDLE,
		ASSERT,
		RELEASE
	} relay_state_t;

	relay_state_t state;

	// Busy for the whole exchange, including the done release
	assign relay_busy = (state != IDLE);

	////////////////////////////////////////
	// Four-phase move FSM

	always_ff @(posedge sys_clk) begin
		if (reset) begin
			state         <= IDLE;
			relay_en      <= 1'b0;
			relay_dir     <= 1'b0;
			relay_channel <= 2'b00;
		end else begin
			case (state)
				// Latch the move, channel and dir stay put until the next start
				IDLE: begin
					if (relay_start) begin
						relay_channel <= relay_cmd.channel;
						relay_dir     <= relay_cmd.dir;
						relay_en      <= 1'b1;
						state         <= ASSERT;
					end
				end

				// Driver finished the move
				ASSERT: begin
					if (relay_done) begin
						relay_en <= 1'b0;
						state    <= RELEASE;
					end
				end

				// Wait for the driver to drop done
				RELEASE: begin
					if (!relay_done)
						state <= IDLE;
				end

				default:
					state <= IDLE;
			endcase
		end
	end

endmodule

// File: fan_tachometer.sv
`timescale 1ns/1ps

module fan_tachometer import mgmt_pkg::*; (
	input wire          sys_clk,
	input wire          reset,

	// Raw tach pin
	input wire          tach,

	// Edges seen in the last full window
	output logic [15:0] tach_count
);

	logic [1:0]            tach_sync;
	logic                  tach_prev;
	logic                  tach_rise;
	logic [TACH_WIN_W-1:0] win_cnt;
	logic [15:0]           edge_cnt;
	logic [15:0]           edge_next;
	logic                  win_end;

	////////////////////////////////////////
	// Pin synchronizer and edge detect

	always_ff @(posedge sys_clk) begin
		if (reset) begin
			tach_sync <= 2'b00;
			tach_prev <= 1'b0;
		end else begin
			tach_sync <= {tach_sync[0], tach};
			tach_prev <= tach_sync[1];
		end
	end

	assign tach_rise = tach_sync[1] & ~tach_prev;

	// Saturate rather than wrap on a very fast fan
	assign edge_next = (tach_rise && (edge_cnt != 16'hFFFF)) ? edge_cnt + 16'd1 : edge_cnt;

	// Last cycle of the counting window
	assign win_end = (win_cnt == TACH_WIN_W'(TACH_WINDOW - 1));

	////////////////////////////////////////
	// Window counter and result latch

	always_ff @(posedge sys_clk) begin
		if (reset) begin
			win_cnt    <= '0;
			edge_cnt   <= '0;
			tach_count <= '0;
		end else if (win_end) begin
			// Edge in the final cycle still counts toward this window
			win_cnt    <= '0;
			edge_cnt   <= '0;
			tach_count <= edge_next;
		end else begin
			win_cnt  <= win_cnt + 1'b1;
			edge_cnt <= edge_next;
		end
	end

endmodule

// File: mgmt_bus_bridge.sv
`timescale 1ns/1ps

module mgmt_bus_bridge import mgmt_pkg::*; (
	input wire              sys_clk,
	input wire              reset,

	// Host side, four-phase req/ack
	input wire              host_req,
	input wire mgmt_req_t   host_cmd,
	output logic            host_ack,
	output mgmt_rsp_t       host_rsp,

	// Internal register bus
	output logic            bus_strobe,
	output mgmt_req_t       bus_cmd,
	input wire              rd_valid,
	input wire mgmt_rsp_t   rd_rsp
);

	typedef enum logic [2:0] {
		IDLE,
		ISSUE,
		WAIT_DATA,
		ACK,
		RELEASE
	} bridge_state_t;

	bridge_state_t state;

	////////////////////////////////////////
	// Handshake FSM

	always_ff @(posedge sys_clk) begin
		if (reset) begin
			state      <= IDLE;
			host_ack   <= 1'b0;
			host_rsp   <= '0;
			bus_strobe <= 1'b0;
		end else begin
			// Strobe is a single cycle pulse
			bus_strobe <= 1'b0;

			case (state)
				// Wait for a new request, ack is already low here
				IDLE: begin
					if (host_req)
						state <= ISSUE;
				end

				// Exactly one strobe per transaction
				ISSUE: begin
					bus_strobe <= 1'b1;
					state      <= WAIT_DATA;
				end

				// Register file answers one cycle after the strobe
				WAIT_DATA: begin
					if (rd_valid) begin
						host_rsp <= rd_rsp;
						host_ack <= 1'b1;
						state    <= ACK;
					end
				end

				// Hold ack for as long as the host keeps req up
				ACK: begin
					if (!host_req) begin
						host_ack <= 1'b0;
						state    <= RELEASE;
					end
				end

				// One guard cycle before the next request
				RELEASE:
					state <= IDLE;

				default:
					state <= IDLE;
			endcase
		end
	end

	// Command is captured once, host keeps it stable anyway
	always_ff @(posedge sys_clk) begin
		if ((state == IDLE) && host_req)
			bus_cmd <= host_cmd;
	end

endmodule

// File: mgmt_pkg.sv
package mgmt_pkg;

	////////////////////////////////////////
	// Sizing of the subsystem

	// Two fan tachometers on the chassis
	localparam int NUM_FANS = 2;

	// One mux select per trigger output
	localparam int NUM_TRIG_OUT = 12;

	// Tach counting window in sys_clk cycles
	localparam int TACH_WINDOW = 1000;
	localparam int TACH_WIN_W = $clog2(TACH_WINDOW);

	// SCK half period in sys_clk cycles
	localparam int SPI_HALF_DIV = 4;
	localparam int SPI_DIV_W = (SPI_HALF_DIV > 1) ? $clog2(SPI_HALF_DIV) : 1;

	// Index widths for the banked registers
	localparam int FAN_IDX_W = (NUM_FANS > 1) ? $clog2(NUM_FANS) : 1;
	localparam int MUX_IDX_W = $clog2(NUM_TRIG_OUT);

	// Fixed identification word
	localparam logic [15:0] MGMT_ID = 16'h5A17;

	////////////////////////////////////////
	// Register access types

	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} reg_op_t;

	// Byte addresses of the register map
	typedef enum logic [7:0] {
		REG_ID          = 8'h00,
		REG_SCRATCH     = 8'h01,
		REG_FAN_BASE    = 8'h10,
		REG_MUXSEL_BASE = 8'h20,
		REG_RELAY_CTRL  = 8'h30,
		REG_RELAY_STAT  = 8'h31,
		REG_FRONT_DATA  = 8'h40,
		REG_FRONT_STAT  = 8'h41
	} reg_addr_t;

	// Host or bus command
	typedef struct packed {
		reg_op_t     op;
		logic [7:0]  addr;
		logic [15:0] wdata;
	} mgmt_req_t;

	// Response, zero for writes
	typedef struct packed {
		logic [15:0] rdata;
	} mgmt_rsp_t;

	// One trigger output mux select
	typedef logic [3:0] muxsel_t;

	// Relay move, laid out to match the control register bits
	typedef struct packed {
		logic [1:0] channel;
		logic       dir;
	} relay_cmd_t;

endpackage
